/* src.f */
+incdir+include
src/macc_pkg.sv
src/delay_line.sv
src/operand_reader.sv
src/muladd.sv
src/result_writer.sv
src/macc_engine.sv
sim/tb_clock_gen.sv
sim/tb_macc_engine.sv

/* Bender.yml */
package:
  name: macc_engine

sources:
  - include_dirs:
      - include
    files:
      - src/macc_pkg.sv
      - src/delay_line.sv
      - src/operand_reader.sv
      - src/muladd.sv
      - src/result_writer.sv
      - src/macc_engine.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_macc_engine.sv

/* sim/tb_macc_engine.sv */
`timescale 1ns/100ps
`include "macc_config.svh"

module tb_macc_engine;

   localparam int DATA_W = `MACC_DATA_W;
   localparam int DEPTH  = 1 << `MACC_MEM_ADDR_W;

   // cycle budget summed over the run list below
   localparam int NUM_RUNS    = 10;
   localparam int PAIRS_TOTAL = 353;   // iterations x period over all runs
   localparam int READS_TOTAL = 62;    // result words read back
   localparam int CYCLE_LIMIT = 10                              // reset and slack
                              + PAIRS_TOTAL + 20 * NUM_RUNS     // runs
                              + 2 * PAIRS_TOTAL + 4 * NUM_RUNS  // operand loads
                              + 2 * READS_TOTAL + 4 * NUM_RUNS; // read back

   logic                     clk;
   logic                     rst;
   logic                     run;
   logic                     load_en;
   logic                     load_sel;
   macc_pkg::mem_addr_t      load_addr;
   logic [DATA_W-1:0]        load_data;
   macc_pkg::muladd_op_t     opcode;
   macc_pkg::mem_addr_t      iterations;
   macc_pkg::period_t        period;
   logic [`MACC_SHIFT_W-1:0] shift;
   macc_pkg::mem_addr_t      res_addr;
   logic [DATA_W-1:0]        res_data;
   logic                     done;

   int seed      = 32'h69cb;
   int cycle_cnt = 0;

   logic signed [DATA_W-1:0] opa_mem [DEPTH];   // copies of what was loaded
   logic signed [DATA_W-1:0] opb_mem [DEPTH];
   logic [DATA_W-1:0]        exp_mem [DEPTH];   // expected result memory

   tb_clock_gen clock_gen_i (
      .clk (clk),
      .rst (rst)
   );

   macc_engine macc_engine_i (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .load_en    (load_en),
      .load_sel   (load_sel),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .opcode     (opcode),
      .iterations (iterations),
      .period     (period),
      .shift      (shift),
      .res_addr   (res_addr),
      .res_data   (res_data),
      .done       (done)
   );

   // --------------------
   // checks and model
   // --------------------
   task automatic check_value(input string what, input int index,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (actual !== expected) begin
         $display("** Error at %0t: %s, index %0d, expected %0h, got %0h",
                  $time, what, index, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // first product of an iteration loads and later ones add or subtract
   function automatic logic [DATA_W-1:0] model_result(input int j,
                                                     input macc_pkg::muladd_op_t op,
                                                     input int per, input int shf);
      logic signed [31:0] sum;
      logic signed [31:0] prod;
      logic signed [31:0] a_val;
      logic signed [31:0] b_val;
      sum = '0;
      for (int k = 0; k < per; k++) begin
         a_val = opa_mem[j * per + k];   // sign extended
         b_val = opb_mem[j * per + k];
         prod  = a_val * b_val;
         if (k == 0) begin
            sum = prod;
         end else if (op == macc_pkg::MACC) begin
            sum = sum + prod;
         end else begin
            sum = sum - prod;
         end
      end
      sum = sum >>> shf;
      return sum[DATA_W-1:0];
   endfunction

   // --------------------
   // host side tasks
   // --------------------
   task automatic load_operands(input int count);
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      for (int k = 0; k < count; k++) begin
         a = $random(seed);
         b = $random(seed);
         opa_mem[k] = a;
         opb_mem[k] = b;
         @(posedge clk);
         load_en   <= 1'b1;
         load_sel  <= 1'b0;   // operand A
         load_addr <= macc_pkg::mem_addr_t'(k);
         load_data <= a;
         @(posedge clk);
         load_sel  <= 1'b1;   // operand B
         load_data <= b;
      end
      @(posedge clk);
      load_en <= 1'b0;
   endtask

   task automatic wait_done();
      while (!done) begin
         @(negedge clk);
      end
   endtask

   task automatic read_back(input int first, input int count);
      for (int i = first; i < first + count; i++) begin
         @(posedge clk);
         res_addr <= macc_pkg::mem_addr_t'(i);
         @(posedge clk);   // read register takes the word here
         @(negedge clk);
         check_value("result", i, exp_mem[i], res_data);
      end
   endtask

   task automatic do_run(input macc_pkg::muladd_op_t op, input int iter,
                         input int per, input int shf);
      load_operands(iter * per);
      @(posedge clk);
      opcode     <= op;
      iterations <= macc_pkg::mem_addr_t'(iter);
      period     <= macc_pkg::period_t'(per);
      shift      <= `MACC_SHIFT_W'(shf);
      run        <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      check_value("done not low after run", 0, 0, done);
      wait_done();
      for (int j = 0; j < iter; j++) begin
         exp_mem[j] = model_result(j, op, per, shf);
      end
      read_back(0, iter);
   endtask

   // runaway guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $fatal(1, "simulation timed out");
      end
   end

   // --------------------
   // test sequence
   // --------------------
   initial begin
      run        = 1'b0;
      load_en    = 1'b0;
      load_sel   = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      opcode     = macc_pkg::MACC;
      iterations = '0;
      period     = '0;
      shift      = '0;
      res_addr   = '0;

      @(negedge rst);
      @(posedge clk);

      $display("macc, shift 0, 8 x 4");
      do_run(macc_pkg::MACC, 8, 4, 0);

      $display("msub, shift 0, 6 x 5");
      do_run(macc_pkg::MSUB, 6, 5, 0);

      $display("random shifts, 4 x 8");
      for (int r = 0; r < 3; r++) begin
         do_run(macc_pkg::MACC, 4, 8, {$random(seed)} % 21);
      end

      $display("period 1 and period 32");
      do_run(macc_pkg::MACC, 16, 1, 0);
      do_run(macc_pkg::MACC, 4, 32, 0);

      // nothing gets written so the last results must still be there
      $display("zero iterations");
      do_run(macc_pkg::MACC, 0, 4, 0);
      read_back(0, 4);

      $display("back-to-back runs");
      do_run(macc_pkg::MSUB, 5, 6, 3);
      do_run(macc_pkg::MACC, 7, 3, 1);

      $display("NO ERRORS");
      $finish;
   end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 5,   // 10 ns clock
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // reset held over the first few rising edges
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

/* src/macc_engine.sv */
`timescale 1ns/100ps
`include "macc_config.svh"

module macc_engine (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   // operand load port
   input  logic                     load_en,
   input  logic                     load_sel,    // 0 selects A, 1 selects B
   input  macc_pkg::mem_addr_t      load_addr,
   input  logic [`MACC_DATA_W-1:0]  load_data,
   // configuration, stable during a run
   input  macc_pkg::muladd_op_t     opcode,
   input  macc_pkg::mem_addr_t      iterations,
   input  macc_pkg::period_t        period,
   input  logic [`MACC_SHIFT_W-1:0] shift,
   // result read port
   input  macc_pkg::mem_addr_t      res_addr,
   output logic [`MACC_DATA_W-1:0]  res_data,
   output logic                     done
);

   logic                    load_en_a;
   logic                    load_en_b;
   logic [`MACC_DATA_W-1:0] op_a;
   logic [`MACC_DATA_W-1:0] op_b;
   logic [`MACC_DATA_W-1:0] result;
   logic                    result_valid;
   macc_pkg::mem_addr_t     result_index;

   // --------------------
   // write strobes
   // --------------------
   assign load_en_a = load_en & ~load_sel;
   assign load_en_b = load_en & load_sel;

   operand_reader reader_a (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .iterations (iterations),
      .period     (period),
      .load_en    (load_en_a),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .operand    (op_a)
   );

   operand_reader reader_b (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .iterations (iterations),
      .period     (period),
      .load_en    (load_en_b),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .operand    (op_b)
   );

   // --------------------
   // multiply-accumulate
   // --------------------
   muladd muladd_i (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .opcode       (opcode),
      .iterations   (iterations),
      .period       (period),
      .shift        (shift),
      .in0          (op_a),
      .in1          (op_b),
      .result       (result),
      .result_valid (result_valid),
      .result_index (result_index),
      .done         (done)
   );

   result_writer result_writer_i (
      .clk          (clk),
      .rst          (rst),
      .result       (result),
      .result_valid (result_valid),
      .result_index (result_index),
      .res_addr     (res_addr),
      .res_data     (res_data)
   );

endmodule

/* src/result_writer.sv */
`timescale 1ns/100ps
`include "macc_config.svh"

module result_writer (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`MACC_DATA_W-1:0]  result,
   input  logic                     result_valid,
   input  macc_pkg::mem_addr_t      result_index,
   input  macc_pkg::mem_addr_t      res_addr,
   output logic [`MACC_DATA_W-1:0]  res_data
);

   localparam int unsigned DEPTH = 1 << `MACC_MEM_ADDR_W;

   logic [`MACC_DATA_W-1:0] mem [DEPTH];   // one word per iteration

   // --------------------
   // write side
   // --------------------
   always_ff @(posedge clk) begin
      if (result_valid) begin
         mem[result_index] <= result;
      end
   end

   // --------------------
   // host read side
   // --------------------
   // res_data follows res_addr by one cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         res_data <= '0;
      end else begin
         res_data <= mem[res_addr];
      end
   end

endmodule

/* src/muladd.sv */
`timescale 1ns/100ps
`include "macc_config.svh"

module muladd (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  macc_pkg::muladd_op_t     opcode,
   input  macc_pkg::mem_addr_t      iterations,
   input  macc_pkg::period_t        period,
   input  logic [`MACC_SHIFT_W-1:0] shift,
   input  logic [`MACC_DATA_W-1:0]  in0,
   input  logic [`MACC_DATA_W-1:0]  in1,
   output logic [`MACC_DATA_W-1:0]  result,
   output logic                     result_valid,
   output macc_pkg::mem_addr_t      result_index,
   output logic                     done
);

   localparam int unsigned DATA_W      = `MACC_DATA_W;
   localparam int unsigned ACC_W       = 2 * DATA_W;
   // operand read latency plus the input and product registers
   localparam int unsigned START_DELAY = `MACC_READ_LAT + 2;
   localparam int unsigned DELAY_W     = $clog2(START_DELAY + 1);
   // accumulator and output register between period end and result
   localparam int unsigned OUT_LAT     = 2;

   logic [DELAY_W-1:0]  delay_cnt;
   logic                counting;     // period/iteration counters are live
   macc_pkg::period_t   period_cnt;
   macc_pkg::mem_addr_t iter_cnt;
   logic                period_last;
   logic                iter_last;

   logic signed [DATA_W-1:0] in0_q;
   logic signed [DATA_W-1:0] in1_q;
   logic signed [ACC_W-1:0]  prod_q;
   logic signed [ACC_W-1:0]  acc_q;
   logic signed [ACC_W-1:0]  acc_shifted;

   // --------------------
   // control counters
   // --------------------
   assign period_last = counting && (period_cnt == period - 1'b1);
   assign iter_last   = (iter_cnt == iterations - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay_cnt  <= '0;
         counting   <= 1'b0;
         period_cnt <= '0;
         iter_cnt   <= '0;
      end else if (run) begin
         delay_cnt  <= DELAY_W'(START_DELAY);
         counting   <= 1'b0;
         period_cnt <= '0;
         iter_cnt   <= '0;
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
         if (delay_cnt == 1'b1 && iterations != '0) begin
            counting <= 1'b1;   // first product reaches the accumulator next
         end
      end else if (counting) begin
         period_cnt <= period_cnt + 1'b1;
         if (period_last) begin
            period_cnt <= '0;
            iter_cnt   <= iter_cnt + 1'b1;
            if (iter_last) begin
               counting <= 1'b0;
            end
         end
      end
   end

   // done drops on run and rises once the last result has been written
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done <= 1'b0;
      end else if (run) begin
         done <= 1'b0;
      end else if (delay_cnt == 1'b1 && iterations == '0) begin
         done <= 1'b1;   // empty run, nothing to wait for
      end else if (result_valid && result_index == iterations - 1'b1) begin
         done <= 1'b1;
      end
   end

   // --------------------
   // datapath
   // --------------------
   assign acc_shifted = acc_q >>> shift;   // arithmetic, acc_q is signed

   always_ff @(posedge clk) begin
      in0_q  <= in0;
      in1_q  <= in1;
      prod_q <= in0_q * in1_q;   // full-width signed product

      if (period_cnt == '0) begin
         acc_q <= prod_q;   // first product of the period
      end else if (opcode == macc_pkg::MACC) begin
         acc_q <= acc_q + prod_q;
      end else begin
         acc_q <= acc_q - prod_q;
      end

      result <= acc_shifted[DATA_W-1:0];
   end

   // period end strobe and index follow the sum through acc and output reg
   delay_line #(
      .DEPTH (OUT_LAT),
      .T     (logic)
   ) valid_dly (
      .clk (clk),
      .rst (rst),
      .d   (period_last),
      .q   (result_valid)
   );

   delay_line #(
      .DEPTH (OUT_LAT),
      .T     (macc_pkg::mem_addr_t)
   ) index_dly (
      .clk (clk),
      .rst (rst),
      .d   (iter_cnt),
      .q   (result_index)
   );

endmodule

/* src/operand_reader.sv */
`timescale 1ns/100ps
`include "macc_config.svh"

module operand_reader (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   input  macc_pkg::mem_addr_t      iterations,
   input  macc_pkg::period_t        period,
   input  logic                     load_en,
   input  macc_pkg::mem_addr_t      load_addr,
   input  logic [`MACC_DATA_W-1:0]  load_data,
   output logic [`MACC_DATA_W-1:0]  operand
);

   localparam int unsigned DEPTH = 1 << `MACC_MEM_ADDR_W;
   localparam int unsigned CNT_W = `MACC_MEM_ADDR_W + `MACC_PERIOD_W;

   logic [`MACC_DATA_W-1:0] mem [DEPTH];

   logic [CNT_W-1:0]    run_len;    // operand pairs in one run
   logic [CNT_W-1:0]    remain_q;   // pairs still to be addressed
   macc_pkg::mem_addr_t addr_q;
   logic                active;

   assign run_len = iterations * period;

   // --------------------
   // address stream
   // --------------------
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active   <= 1'b0;
         addr_q   <= '0;
         remain_q <= '0;
      end else if (run) begin
         active   <= (run_len != '0);   // nothing to stream for an empty run
         addr_q   <= '0;
         remain_q <= run_len;
      end else if (active) begin
         addr_q   <= addr_q + 1'b1;
         remain_q <= remain_q - 1'b1;
         if (remain_q == 1'b1) begin
            active <= 1'b0;   // last address goes out this cycle
         end
      end
   end

   // --------------------
   // operand memory
   // --------------------
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;   // host write port
      end
   end

   // synchronous read, one cycle of latency
   always_ff @(posedge clk) begin
      if (active) begin
         operand <= mem[addr_q];
      end
   end

endmodule

/* src/delay_line.sv */
`timescale 1ns/100ps

module delay_line #(
   parameter int unsigned DEPTH = 2,
   parameter type T = logic
) (
   input  logic clk,
   input  logic rst,
   input  T     d,
   output T     q
);

   T stage_q [DEPTH];   // stage 0 takes d, last stage drives q

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            stage_q[i] <= '0;
         end
      end else begin
         stage_q[0] <= d;
         for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign q = stage_q[DEPTH-1];

endmodule

/* src/macc_pkg.sv */
`include "macc_config.svh"

package macc_pkg;

   // --------------------
   // accumulate mode
   // --------------------
   typedef enum logic {
      MACC = 1'b0,   // add later products
      MSUB = 1'b1    // subtract later products
   } muladd_op_t;

   // memory address, also used as iteration index
   typedef logic [`MACC_MEM_ADDR_W-1:0] mem_addr_t;

   // products per iteration
   typedef logic [`MACC_PERIOD_W-1:0] period_t;

endpackage

/* include/macc_config.svh */
`ifndef MACC_CONFIG_SVH
`define MACC_CONFIG_SVH

// operand and result word width
`define MACC_DATA_W 16

// operand / result memory address width, 256 words each
`define MACC_MEM_ADDR_W 8

// width of the period setting
`define MACC_PERIOD_W 8

// width of the arithmetic shift applied to the finished sum
`define MACC_SHIFT_W 6

// cycles from operand address to data at the muladd inputs
`define MACC_READ_LAT 1

`endif
